// ==== files.f ====
source/icache_pkg.sv
source/icache_ctrl_regs.sv
source/icache_core.sv
source/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module icache_tb -o icache_sim

out=$(./obj_dir/icache_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// ==== bench/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    localparam int INDEX_BITS = 4;
    localparam int CNT_BITS   = 16;
    localparam int LINES      = 1 << INDEX_BITS;
    localparam int TAG_BITS   = 30 - INDEX_BITS;
    localparam int WAIT_LIMIT = 200;

    logic       clk = 1'b0;
    logic       rst;
    addr_t      cpu_addr;
    logic       cpu_valid;
    logic       cpu_ready;
    word_t      cpu_data;
    addr_t      mem_addr;
    logic       mem_valid;
    logic       mem_ready;
    word_t      mem_data;
    cfg_bus_t   cfg;
    logic [1:0] cfg_rsel;
    word_t      cfg_rdata;

    // reference model of the cache contents
    logic                model_valid [LINES];
    logic [TAG_BITS-1:0] model_tag [LINES];
    logic                model_enable;
    int                  model_hits;
    int                  model_misses;

    always #2 clk = ~clk;

    icache_top #(
        .INDEX_BITS (INDEX_BITS),
        .CNT_BITS   (CNT_BITS)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_data  (cpu_data),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data),
        .cfg       (cfg),
        .cfg_rsel  (cfg_rsel),
        .cfg_rdata (cfg_rdata)
    );

    icache_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data)
    );

    function automatic word_t expected_word(input addr_t addr);
        word_t w;
        w = {addr[31:2], 2'b00} ^ 32'h5bd1_e995;
        w = w ^ (w >> 15);
        w = w * 32'h2c1b_3c6d;
        w = w ^ (w >> 12);
        return w;
    endfunction

    // 48 words over 16 lines, so tags collide often
    function automatic addr_t random_address();
        word_t w;
        w = $urandom_range(47, 0);
        return 32'h0000_4000 + (w << 2);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "wait limit reached");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_status(input word_t got, input logic exp_enable,
                                input logic exp_busy, input string what);
        if ((got[0] !== exp_enable) || (got[2] !== exp_busy))
            report_error($sformatf("%s: enable %b busy %b, expected %b %b",
                                   what, got[0], got[2], exp_enable, exp_busy));
    endtask

    task automatic check_latency(input int got, input logic exp_hit, input addr_t addr);
        if (exp_hit && (got != 2))
            report_error($sformatf("hit on %h took %0d cycles, expected 2", addr, got));
        else if (!exp_hit && (got <= 2))
            report_error($sformatf("miss on %h answered in %0d cycles", addr, got));
    endtask

    // all of these start and end just after a falling edge
    task automatic reg_write(input logic [1:0] sel, input word_t data);
        cfg.wr    = 1'b1;
        cfg.sel   = sel;
        cfg.wdata = data;
        @(negedge clk);
        cfg = '0;
    endtask

    task automatic reg_read(input logic [1:0] sel, output word_t data);
        cfg_rsel = sel;
        #1;
        data = cfg_rdata;
        @(negedge clk);
    endtask

    task automatic wait_flush_done(output int busy_cycles);
        word_t ctrl;
        busy_cycles = 0;
        reg_read(REG_CTRL, ctrl);
        while (ctrl[2])
        begin
            busy_cycles++;
            if (busy_cycles >= WAIT_LIMIT)
                report_timeout("flush_busy to clear");
            reg_read(REG_CTRL, ctrl);
        end
    endtask

    task automatic fetch_check(input addr_t addr);
        logic [INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]   tag;
        logic                  exp_hit;
        logic                  done;
        logic                  saw_mem;
        word_t                 got;
        int                    cycles;
        idx     = addr[INDEX_BITS+1:2];
        tag     = addr[31:INDEX_BITS+2];
        exp_hit = model_enable && model_valid[idx] && (model_tag[idx] == tag);
        cpu_addr  = addr;
        cpu_valid = 1'b1;
        cycles    = 0;
        done      = 1'b0;
        saw_mem   = 1'b0;
        got       = '0;
        while (!done)
        begin
            #1;
            cycles++;
            if (mem_valid)
            begin
                saw_mem = 1'b1;
                check_addr(mem_addr, {addr[31:2], 2'b00},
                           $sformatf("memory address for %h", addr));
            end
            if (cpu_ready)
            begin
                got  = cpu_data;
                done = 1'b1;
            end
            else if (cycles >= WAIT_LIMIT)
                report_timeout("cpu_ready on a fetch");
            @(negedge clk);
        end
        cpu_valid = 1'b0;
        check_word(got, expected_word(addr), $sformatf("fetch data at %h", addr));
        check_latency(cycles, exp_hit, addr);
        if (exp_hit && saw_mem)
            report_error($sformatf("memory request on a hit at %h", addr));
        else if (!exp_hit && !saw_mem)
            report_error($sformatf("no memory request on a miss at %h", addr));
        if (exp_hit)
            model_hits++;
        else
        begin
            model_misses++;
            // a disabled cache leaves the line alone
            if (model_enable)
            begin
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
            end
        end
    endtask

    task automatic check_counters(input string phase);
        word_t rd;
        reg_read(REG_HITS, rd);
        check_word(rd, word_t'(model_hits), {"hit count ", phase});
        reg_read(REG_MISSES, rd);
        check_word(rd, word_t'(model_misses), {"miss count ", phase});
        reg_write(REG_HITS, '0);
        reg_write(REG_MISSES, '0);
        reg_read(REG_HITS, rd);
        check_word(rd, '0, {"hit count cleared ", phase});
        reg_read(REG_MISSES, rd);
        check_word(rd, '0, {"miss count cleared ", phase});
        model_hits   = 0;
        model_misses = 0;
    endtask

    initial
    begin
        word_t rd;
        int    busy;
        addr_t cached[$];

        void'($urandom(32'ha099));
        rst          = 1'b1;
        cpu_addr     = '0;
        cpu_valid    = 1'b0;
        cfg          = '0;
        cfg_rsel     = REG_CTRL;
        model_enable = 1'b1;
        model_hits   = 0;
        model_misses = 0;
        for (int i = 0; i < LINES; i++)
        begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        wait_flush_done(busy);
        reg_read(REG_CTRL, rd);
        check_status(rd, 1'b1, 1'b0, "control after reset");
        check_counters("after reset");

        repeat (200) fetch_check(random_address());
        check_counters("after random burst");

        // bypass mode, every fetch a miss
        reg_write(REG_CTRL, 32'h0);
        model_enable = 1'b0;
        reg_read(REG_CTRL, rd);
        check_status(rd, 1'b0, 1'b0, "control with cache disabled");
        repeat (40) fetch_check(random_address());
        check_counters("with cache disabled");

        reg_write(REG_CTRL, 32'h1);
        model_enable = 1'b1;
        repeat (100) fetch_check(random_address());
        check_counters("after re-enable");

        for (int i = 0; i < LINES; i++)
        begin
            if (model_valid[i])
                cached.push_back({model_tag[i], INDEX_BITS'(i), 2'b00});
        end
        if (cached.size() == 0)
            report_error("no valid line to test the flush with");

        reg_write(REG_CTRL, 32'h3);
        reg_read(REG_CTRL, rd);
        check_status(rd, 1'b1, 1'b1, "control during flush");
        wait_flush_done(busy);
        if (busy < LINES)
            report_error($sformatf("flush_busy low after %0d cycles", busy));
        for (int i = 0; i < LINES; i++)
            model_valid[i] = 1'b0;

        // each line that hit before: one miss, then a hit
        foreach (cached[i])
        begin
            fetch_check(cached[i]);
            fetch_check(cached[i]);
        end
        check_counters("after flush");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== bench/icache_mem_model.sv ====
`timescale 1ns/100ps

module icache_mem_model import icache_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t mem_addr,
    input  logic  mem_valid,
    output logic  mem_ready,
    output word_t mem_data
);

    int   delay;
    logic busy;

    // word contents depend on the whole word address
    function automatic word_t mix_word(input addr_t addr);
        word_t w;
        w = {addr[31:2], 2'b00} ^ 32'h5bd1_e995;
        w = w ^ (w >> 15);
        w = w * 32'h2c1b_3c6d;
        w = w ^ (w >> 12);
        return w;
    endfunction

    initial
    begin
        mem_ready = 1'b0;
        mem_data  = '0;
        busy      = 1'b0;
        delay     = 0;
        forever
        begin
            @(negedge clk);
            if (rst || !mem_valid || mem_ready)
            begin
                mem_ready = 1'b0;
                busy      = 1'b0;
            end
            else
            begin
                // new request, pick a ready delay of 0 to 5 cycles
                if (!busy)
                begin
                    delay = $urandom_range(5, 0);
                    busy  = 1'b1;
                end
                if (delay == 0)
                begin
                    mem_ready = 1'b1;
                    mem_data  = mix_word(mem_addr);
                end
                else
                    delay = delay - 1;
            end
        end
    end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/100ps

module icache_top import icache_pkg::*; #(
    parameter int INDEX_BITS = 4,
    parameter int CNT_BITS   = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      cpu_addr,
    input  logic       cpu_valid,
    output logic       cpu_ready,
    output word_t      cpu_data,
    output addr_t      mem_addr,
    output logic       mem_valid,
    input  logic       mem_ready,
    input  word_t      mem_data,
    input  cfg_bus_t   cfg,
    input  logic [1:0] cfg_rsel,
    output word_t      cfg_rdata
);

    cache_cfg_t    cache_cfg;
    cache_status_t cache_status;

    icache_ctrl_regs #(
        .CNT_BITS (CNT_BITS)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .cfg_rsel  (cfg_rsel),
        .cfg_rdata (cfg_rdata),
        .cache_cfg (cache_cfg),
        .status    (cache_status)
    );

    icache_core #(
        .INDEX_BITS (INDEX_BITS)
    ) u_core (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_data  (cpu_data),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data),
        .cfg       (cache_cfg),
        .status    (cache_status)
    );

endmodule

// ==== source/icache_core.sv ====
`timescale 1ns/100ps

module icache_core import icache_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  addr_t         cpu_addr,
    input  logic          cpu_valid,
    output logic          cpu_ready,
    output word_t         cpu_data,
    output addr_t         mem_addr,
    output logic          mem_valid,
    input  logic          mem_ready,
    input  word_t         mem_data,
    input  cache_cfg_t    cfg,
    output cache_status_t status
);

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = 32 - 2 - INDEX_BITS;

    icache_state_t state;
    icache_state_t next_state;

    logic [LINES-1:0]    valid_q;
    logic [TAG_BITS-1:0] tag_q [LINES];
    word_t               data_q [LINES];

    addr_t               req_addr;
    logic [INDEX_BITS-1:0] req_idx;
    logic [TAG_BITS-1:0] req_tag;
    logic [INDEX_BITS-1:0] flush_idx;

    logic flush_pending;
    logic bypass_q;
    logic filled_q;
    logic mem_valid_q;
    logic hit;
    logic fill_done;

    assign req_idx = req_addr[INDEX_BITS+1:2];
    assign req_tag = req_addr[31:INDEX_BITS+2];

    // a disabled cache never hits
    assign hit = cfg.enable && valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign fill_done = (state == ALLOCATE) && mem_ready;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (flush_pending || cfg.flush_req)
                    next_state = FLUSH;
                else if (cpu_valid)
                    next_state = LOOKUP;
            end
            LOOKUP:
            begin
                if (hit)
                    next_state = IDLE;
                else
                    next_state = ALLOCATE;
            end
            ALLOCATE:
            begin
                if (mem_ready)
                    next_state = bypass_q ? IDLE : LOOKUP;
            end
            FLUSH:
            begin
                if (flush_idx == INDEX_BITS'(LINES - 1))
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // reset walks the whole array through FLUSH
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state         <= FLUSH;
            flush_idx     <= '0;
            flush_pending <= 1'b0;
            bypass_q      <= 1'b0;
            filled_q      <= 1'b0;
            mem_valid_q   <= 1'b0;
        end
        else
        begin
            state <= next_state;

            if (state == FLUSH)
                flush_idx <= flush_idx + 1'b1;

            // any pending flush is taken from IDLE
            if (state == IDLE)
                flush_pending <= 1'b0;
            else if (cfg.flush_req)
                flush_pending <= 1'b1;

            if (state == LOOKUP)
                bypass_q <= !cfg.enable;

            if (state == IDLE)
                filled_q <= 1'b0;
            else if (fill_done)
                filled_q <= 1'b1;

            // memory request from the miss until mem_ready
            if ((state == LOOKUP) && !hit)
                mem_valid_q <= 1'b1;
            else if (mem_valid_q && mem_ready)
                mem_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && cpu_valid)
            req_addr <= cpu_addr;
    end

    always_ff @(posedge clk)
    begin
        if (state == FLUSH)
            valid_q[flush_idx] <= 1'b0;
        else if (fill_done && !bypass_q)
            valid_q[req_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill_done && !bypass_q)
        begin
            tag_q[req_idx]  <= req_tag;
            data_q[req_idx] <= mem_data;
        end
    end

    // hit from LOOKUP, or the bypassed word straight from memory
    assign cpu_ready = ((state == LOOKUP) && hit) || (fill_done && bypass_q);
    assign cpu_data  = (state == ALLOCATE) ? mem_data : data_q[req_idx];

    assign mem_valid = mem_valid_q;
    assign mem_addr  = {req_addr[31:2], 2'b00};

    // second lookup after a fill is not counted
    assign status.hit_pulse  = (state == LOOKUP) && hit && !filled_q;
    assign status.miss_pulse = (state == LOOKUP) && !hit;
    assign status.flush_busy = cfg.flush_req || flush_pending || (state == FLUSH);

    a_mem_valid_alloc: assert property (@(posedge clk) disable iff (rst)
        mem_valid |-> (state == ALLOCATE));

    a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && !mem_ready) |=> $stable(mem_addr));

    // processor must still be waiting when the word comes back
    a_ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |-> cpu_valid);

endmodule

// ==== source/icache_ctrl_regs.sv ====
`timescale 1ns/100ps

module icache_ctrl_regs import icache_pkg::*; #(
    parameter int CNT_BITS = 16
) (
    input  logic          clk,
    input  logic          rst,
    input  cfg_bus_t      cfg,
    input  logic [1:0]    cfg_rsel,
    output word_t         cfg_rdata,
    output cache_cfg_t    cache_cfg,
    input  cache_status_t status
);

    logic                enable_q;
    logic                flush_q;
    logic [CNT_BITS-1:0] hit_cnt;
    logic [CNT_BITS-1:0] miss_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end
        else
        begin
            // flush request lasts one cycle
            flush_q <= cfg.wr && (cfg.sel == REG_CTRL) && cfg.wdata[1];
            if (cfg.wr && (cfg.sel == REG_CTRL))
                enable_q <= cfg.wdata[0];

            // a write clears, otherwise count up and stick at max
            if (cfg.wr && (cfg.sel == REG_HITS))
                hit_cnt <= '0;
            else if (status.hit_pulse && (hit_cnt != '1))
                hit_cnt <= hit_cnt + 1'b1;

            if (cfg.wr && (cfg.sel == REG_MISSES))
                miss_cnt <= '0;
            else if (status.miss_pulse && (miss_cnt != '1))
                miss_cnt <= miss_cnt + 1'b1;
        end
    end

    assign cache_cfg = '{enable: enable_q, flush_req: flush_q};

    always_comb
    begin
        case (cfg_rsel)
            REG_CTRL:   cfg_rdata = {29'd0, status.flush_busy, 1'b0, enable_q};
            REG_HITS:   cfg_rdata = word_t'(hit_cnt);
            REG_MISSES: cfg_rdata = word_t'(miss_cnt);
            default:    cfg_rdata = '0;
        endcase
    end

    // one lookup gives either a hit or a miss, never both
    a_one_pulse: assert property (@(posedge clk) disable iff (rst)
        !(status.hit_pulse && status.miss_pulse));

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

    typedef logic [31:0] word_t;

    // byte address, bits 1:0 are the word offset
    typedef logic [31:0] addr_t;

    // register block to core
    typedef struct packed {
        logic enable;
        logic flush_req;
    } cache_cfg_t;

    // core to register block
    typedef struct packed {
        logic hit_pulse;
        logic miss_pulse;
        logic flush_busy;
    } cache_status_t;

    // register write side
    typedef struct packed {
        logic       wr;
        logic [1:0] sel;
        word_t      wdata;
    } cfg_bus_t;

    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_HITS   = 2'd1;
    localparam logic [1:0] REG_MISSES = 2'd2;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        ALLOCATE,
        FLUSH
    } icache_state_t;

endpackage
